//--- source/led_panel_pkg.sv
// LED panel shared definitions
`default_nettype none

package led_panel_pkg;

    // ==============================
    // Sizes and fixed options
    // ==============================
    localparam int LED_COUNT    = 8;
    localparam int SREG_BITS    = 2 * LED_COUNT;      // Red and green per LED
    localparam int PRESCALE     = 3;                  // Tick every PRESCALE+1 clk
    localparam bit SREG_INVERT  = 1'b0;
    localparam bit SREG_REVERSE = 1'b0;               // Set to shift top bit first
    localparam int BLINK_W      = 24;
    localparam int WB_ADDR_W    = 2;
    localparam int WB_DATA_W    = 32;
    localparam int PRESCALE_W   = $clog2(PRESCALE + 1);
    localparam int BIT_IDX_W    = $clog2(SREG_BITS);

    // ==============================
    // Types
    // ==============================
    typedef logic [LED_COUNT-1:0]  led_vec_t;
    typedef logic [SREG_BITS-1:0]  sreg_frame_t;      // Bit 2i red, 2i+1 green
    typedef logic [BLINK_W-1:0]    blink_cnt_t;
    typedef logic [WB_ADDR_W-1:0]  wb_addr_t;
    typedef logic [WB_DATA_W-1:0]  wb_data_t;
    typedef logic [PRESCALE_W-1:0] presc_cnt_t;
    typedef logic [BIT_IDX_W-1:0]  bit_idx_t;

    localparam presc_cnt_t PRESCALE_RELOAD = presc_cnt_t'(PRESCALE);
    localparam bit_idx_t   BIT_LAST        = bit_idx_t'(SREG_BITS - 1);

    // Register map
    localparam wb_addr_t REG_RED        = 2'd0;
    localparam wb_addr_t REG_GREEN      = 2'd1;
    localparam wb_addr_t REG_BLINK_MASK = 2'd2;
    localparam wb_addr_t REG_BLINK_HALF = 2'd3;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef struct packed {
        led_vec_t   red;
        led_vec_t   green;
        led_vec_t   blink_mask;
        blink_cnt_t blink_half;
    } led_cfg_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_DATA,
        SER_CLK,
        SER_LATCH
    } ser_state_t;

endpackage

`default_nettype wire

//--- source/led_wb_regs.sv
// Wishbone control registers
`timescale 1ns/100ps
`default_nettype none

module led_wb_regs (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire led_panel_pkg::wb_req_t wb_req,
    output led_panel_pkg::wb_rsp_t      wb_rsp,
    output led_panel_pkg::led_cfg_t     cfg
);

    logic                     req;
    logic                     served;       // Request already answered
    logic                     take;
    logic                     ack_reg;
    led_panel_pkg::wb_data_t  rdat_reg;
    led_panel_pkg::wb_data_t  rdat_next;
    led_panel_pkg::led_cfg_t  cfg_reg;

    assign req  = wb_req.cyc && wb_req.stb;
    assign take = req && !served;

    // ==============================
    // Readback mux
    // ==============================
    always_comb begin
        case (wb_req.adr)
            led_panel_pkg::REG_RED: begin
                rdat_next = led_panel_pkg::wb_data_t'(cfg_reg.red);
            end
            led_panel_pkg::REG_GREEN: begin
                rdat_next = led_panel_pkg::wb_data_t'(cfg_reg.green);
            end
            led_panel_pkg::REG_BLINK_MASK: begin
                rdat_next = led_panel_pkg::wb_data_t'(cfg_reg.blink_mask);
            end
            default: begin
                rdat_next = led_panel_pkg::wb_data_t'(cfg_reg.blink_half);
            end
        endcase
    end

    // ==============================
    // Handshake and register writes
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_reg <= 1'b0;
            served  <= 1'b0;
            cfg_reg <= '0;
        end else begin
            ack_reg <= take;
            served  <= req;                   // Cleared once stb drops
            if (take && wb_req.we) begin
                case (wb_req.adr)
                    led_panel_pkg::REG_RED: begin
                        cfg_reg.red <= wb_req.dat[led_panel_pkg::LED_COUNT-1:0];
                    end
                    led_panel_pkg::REG_GREEN: begin
                        cfg_reg.green <= wb_req.dat[led_panel_pkg::LED_COUNT-1:0];
                    end
                    led_panel_pkg::REG_BLINK_MASK: begin
                        cfg_reg.blink_mask <= wb_req.dat[led_panel_pkg::LED_COUNT-1:0];
                    end
                    default: begin
                        cfg_reg.blink_half <= wb_req.dat[led_panel_pkg::BLINK_W-1:0];
                    end
                endcase
            end
        end
    end

    // Read data held with ack
    always_ff @(posedge clk) begin
        if (take) begin
            rdat_reg <= rdat_next;
        end
    end

    assign wb_rsp.ack = ack_reg;
    assign wb_rsp.dat = rdat_reg;
    assign cfg        = cfg_reg;

    // Every ack answers a request seen one clk earlier
    ack_follows_req: assert property (
        @(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    );

endmodule

`default_nettype wire

//--- source/led_blink.sv
// Blink phase and frame builder
`timescale 1ns/100ps
`default_nettype none

module led_blink (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire led_panel_pkg::led_cfg_t cfg,
    output led_panel_pkg::sreg_frame_t   frame
);

    led_panel_pkg::blink_cnt_t  half_cnt;
    led_panel_pkg::blink_cnt_t  half_prev;
    logic                       dark;        // High during the off half
    led_panel_pkg::led_vec_t    off_mask;
    led_panel_pkg::sreg_frame_t frame_next;
    led_panel_pkg::sreg_frame_t frame_reg;

    // ==============================
    // Phase counter
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            half_cnt  <= '0;
            half_prev <= '0;
            dark      <= 1'b0;
        end else begin
            half_prev <= cfg.blink_half;
            if (cfg.blink_half == '0) begin
                half_cnt <= '0;                     // Blinking off, stay lit
                dark     <= 1'b0;
            end else if (cfg.blink_half != half_prev) begin
                half_cnt <= cfg.blink_half;         // Restart on new period
                dark     <= 1'b0;
            end else if (half_cnt == '0) begin
                half_cnt <= cfg.blink_half;
                dark     <= !dark;
            end else begin
                half_cnt <= half_cnt - 1'b1;
            end
        end
    end

    // ==============================
    // Frame assembly
    // ==============================
    assign off_mask = dark ? cfg.blink_mask : '0;

    always_comb begin
        frame_next = '0;
        for (int i = 0; i < led_panel_pkg::LED_COUNT; i++) begin
            frame_next[2*i]   = cfg.red[i] && !off_mask[i];
            frame_next[2*i+1] = cfg.green[i] && !off_mask[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg <= '0;
        end else begin
            frame_reg <= frame_next;
        end
    end

    assign frame = frame_reg;

    // A zero half-period keeps the panel lit
    lit_when_frozen: assert property (
        @(posedge clk) disable iff (rst)
        (cfg.blink_half == '0) |=> !dark
    );

endmodule

`default_nettype wire

//--- source/led_sreg_ser.sv
// Shift register chain serializer
`timescale 1ns/100ps
`default_nettype none

module led_sreg_ser (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire led_panel_pkg::sreg_frame_t frame,
    output logic                            sreg_d,
    output logic                            sreg_clk,
    output logic                            sreg_ld
);

    led_panel_pkg::presc_cnt_t  pre_cnt;
    logic                       tick;
    logic                       start;
    logic                       pending;     // New frame waiting
    led_panel_pkg::sreg_frame_t last_frame;
    led_panel_pkg::sreg_frame_t shadow;      // Frame being shifted
    led_panel_pkg::bit_idx_t    bit_idx;
    led_panel_pkg::ser_state_t  state;
    logic                       d_reg;
    logic                       clk_reg;
    logic                       ld_reg;

    // Picks the next bit in shift order
    function automatic logic pick_bit(
        input led_panel_pkg::sreg_frame_t f,
        input led_panel_pkg::bit_idx_t    idx
    );
        if (led_panel_pkg::SREG_REVERSE) begin
            return f[led_panel_pkg::BIT_LAST - idx];
        end
        return f[idx];
    endfunction

    assign tick  = (pre_cnt == '0);
    assign start = tick && (state == led_panel_pkg::SER_IDLE) && pending;

    // ==============================
    // Prescaler and frame tracking
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt    <= '0;
            pending    <= 1'b1;                 // Send a blank frame after reset
            last_frame <= '0;
        end else begin
            pre_cnt <= tick ? led_panel_pkg::PRESCALE_RELOAD : pre_cnt - 1'b1;
            if (start) begin
                last_frame <= frame;
                pending    <= 1'b0;
            end else if (frame != last_frame) begin
                last_frame <= frame;
                pending    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shadow <= frame;
        end
    end

    // ==============================
    // Shift state machine
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= led_panel_pkg::SER_IDLE;
            bit_idx <= '0;
            d_reg   <= 1'b0;
            clk_reg <= 1'b0;
            ld_reg  <= 1'b0;
        end else if (tick) begin
            case (state)
                led_panel_pkg::SER_IDLE: begin
                    if (start) begin
                        bit_idx <= '0;
                        d_reg   <= pick_bit(frame, '0);
                        state   <= led_panel_pkg::SER_DATA;
                    end
                end
                led_panel_pkg::SER_DATA: begin
                    clk_reg <= 1'b1;               // Chain samples here
                    state   <= led_panel_pkg::SER_CLK;
                end
                led_panel_pkg::SER_CLK: begin
                    clk_reg <= 1'b0;
                    if (bit_idx == led_panel_pkg::BIT_LAST) begin
                        d_reg  <= 1'b0;
                        ld_reg <= 1'b1;
                        state  <= led_panel_pkg::SER_LATCH;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        d_reg   <= pick_bit(shadow, bit_idx + 1'b1);
                        state   <= led_panel_pkg::SER_DATA;
                    end
                end
                default: begin
                    ld_reg <= 1'b0;
                    state  <= led_panel_pkg::SER_IDLE;
                end
            endcase
        end
    end

    assign sreg_d   = d_reg ^ led_panel_pkg::SREG_INVERT;
    assign sreg_clk = clk_reg;
    assign sreg_ld  = ld_reg;

    clk_ld_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(sreg_clk && sreg_ld)
    );

    // Latch pulse only comes from the final state
    ld_in_latch: assert property (
        @(posedge clk) disable iff (rst)
        sreg_ld |-> (state == led_panel_pkg::SER_LATCH)
    );

endmodule

`default_nettype wire

//--- source/led_panel_top.sv
// LED panel top level
`timescale 1ns/100ps
`default_nettype none

module led_panel_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire led_panel_pkg::wb_req_t wb_req,
    output wire led_panel_pkg::wb_rsp_t wb_rsp,
    output wire logic                   sreg_d,
    output wire logic                   sreg_clk,
    output wire logic                   sreg_ld
);

    wire led_panel_pkg::led_cfg_t    cfg;
    wire led_panel_pkg::sreg_frame_t frame;

    // ==============================
    // Pipeline stages
    // ==============================

    // Host registers
    led_wb_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg)
    );

    // Blink and frame build
    led_blink u_blink (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .frame (frame)
    );

    // Serial output to the chain
    led_sreg_ser u_ser (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .sreg_d   (sreg_d),
        .sreg_clk (sreg_clk),
        .sreg_ld  (sreg_ld)
    );

endmodule

`default_nettype wire

//--- verif/sreg_chain_model.sv
// Shift register chain model
`timescale 1ns/100ps
`default_nettype none

module sreg_chain_model (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  sreg_d,
    input  wire logic                  sreg_clk,
    input  wire logic                  sreg_ld,
    output led_panel_pkg::sreg_frame_t latched,
    output logic                       latch_stb,    // One clk per latch pulse
    output logic                       count_err
);

    led_panel_pkg::sreg_frame_t chain;
    logic                       clk_q;
    logic                       ld_q;
    int                         pulses;              // Shift clocks since last latch

    // ==============================
    // Shift and latch
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            chain     <= '0;
            clk_q     <= 1'b0;
            ld_q      <= 1'b0;
            pulses    <= 0;
            latched   <= '0;
            latch_stb <= 1'b0;
            count_err <= 1'b0;
        end else begin
            clk_q     <= sreg_clk;
            ld_q      <= sreg_ld;
            latch_stb <= 1'b0;
            if (sreg_clk && !clk_q) begin
                // First bit in ends up at the far end
                chain  <= {sreg_d ^ led_panel_pkg::SREG_INVERT,
                           chain[led_panel_pkg::SREG_BITS-1:1]};
                pulses <= pulses + 1;
            end
            if (sreg_ld && !ld_q) begin
                latched   <= chain;
                latch_stb <= 1'b1;
                pulses    <= 0;
                if (pulses != led_panel_pkg::SREG_BITS) begin
                    count_err <= 1'b1;               // Sticky
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/led_panel_tb.sv
// LED panel testbench
`timescale 1ns/100ps
`default_nettype none

module led_panel_tb;

    localparam int ACK_TIMEOUT   = 20;
    localparam int FRAME_TIMEOUT = 2000;
    localparam int SETTLE_CLKS   = 2 * (2 * led_panel_pkg::SREG_BITS + 1)
                                   * (led_panel_pkg::PRESCALE + 1);    // Two transfers

    logic                            clk;
    logic                            rst;
    led_panel_pkg::wb_req_t          wb_req;
    wire led_panel_pkg::wb_rsp_t     wb_rsp;
    wire logic                       sreg_d;
    wire logic                       sreg_clk;
    wire logic                       sreg_ld;
    wire led_panel_pkg::sreg_frame_t latched;
    wire logic                       latch_stb;
    wire logic                       count_err;

    led_panel_pkg::led_vec_t         cur_red;
    led_panel_pkg::led_vec_t         cur_green;
    led_panel_pkg::led_vec_t         cur_mask;
    led_panel_pkg::sreg_frame_t      allowed[$];     // Frames the chain may latch
    led_panel_pkg::sreg_frame_t      last_latched;
    int                              latch_count;

    led_panel_top led_panel_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .sreg_d   (sreg_d),
        .sreg_clk (sreg_clk),
        .sreg_ld  (sreg_ld)
    );

    sreg_chain_model chain_model (
        .clk       (clk),
        .rst       (rst),
        .sreg_d    (sreg_d),
        .sreg_clk  (sreg_clk),
        .sreg_ld   (sreg_ld),
        .latched   (latched),
        .latch_stb (latch_stb),
        .count_err (count_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Reference and checks
    // ==============================
    function automatic led_panel_pkg::sreg_frame_t expected_frame(
        input led_panel_pkg::led_vec_t red,
        input led_panel_pkg::led_vec_t green,
        input led_panel_pkg::led_vec_t mask,
        input logic                    dark
    );
        led_panel_pkg::sreg_frame_t f;
        led_panel_pkg::sreg_frame_t r;
        for (int i = 0; i < led_panel_pkg::LED_COUNT; i++) begin
            f[2*i]   = red[i] & !(dark & mask[i]);
            f[2*i+1] = green[i] & !(dark & mask[i]);
        end
        for (int b = 0; b < led_panel_pkg::SREG_BITS; b++) begin
            r[b] = f[led_panel_pkg::SREG_BITS-1-b];     // Top bit shifted first
        end
        return led_panel_pkg::SREG_REVERSE ? r : f;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input led_panel_pkg::wb_data_t got,
                                input led_panel_pkg::wb_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_frame(input string name, input led_panel_pkg::sreg_frame_t got,
                               input led_panel_pkg::sreg_frame_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expect_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic bit frame_allowed(input led_panel_pkg::sreg_frame_t f);
        foreach (allowed[k]) begin
            if (allowed[k] == f) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic allow_config();
        allowed.push_back(expected_frame(cur_red, cur_green, cur_mask, 1'b0));
        allowed.push_back(expected_frame(cur_red, cur_green, cur_mask, 1'b1));
    endtask

    // ==============================
    // Wishbone master
    // ==============================
    task automatic bus_cycle(
        input  logic                    we,
        input  led_panel_pkg::wb_addr_t adr,
        input  led_panel_pkg::wb_data_t wdat,
        output led_panel_pkg::wb_data_t rdat
    );
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req = {1'b1, 1'b1, we, adr, wdat};
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("No Wishbone ack before timeout");
            end
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;                                  // Drop stb with the ack
    endtask

    task automatic set_reg(input led_panel_pkg::wb_addr_t adr,
                           input led_panel_pkg::wb_data_t dat);
        led_panel_pkg::wb_data_t ignored;
        bus_cycle(1'b1, adr, dat, ignored);
        case (adr)
            led_panel_pkg::REG_RED:        cur_red   = led_panel_pkg::led_vec_t'(dat);
            led_panel_pkg::REG_GREEN:      cur_green = led_panel_pkg::led_vec_t'(dat);
            led_panel_pkg::REG_BLINK_MASK: cur_mask  = led_panel_pkg::led_vec_t'(dat);
            default: ;
        endcase
        allow_config();
    endtask

    task automatic wait_latch(output led_panel_pkg::sreg_frame_t f);
        int waited;
        int seen;
        waited = 0;
        seen   = latch_count;
        while (latch_count == seen) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                abort_run("No latched frame before timeout");
            end
        end
        f = last_latched;
    endtask

    // Returns once no latch has come for longer than any transfer
    task automatic wait_settled();
        int waited;
        int quiet;
        int seen;
        waited = 0;
        quiet  = 0;
        seen   = latch_count;
        while (quiet < SETTLE_CLKS) begin
            @(negedge clk);
            waited++;
            quiet = (latch_count == seen) ? quiet + 1 : 0;
            seen  = latch_count;
            if (waited > FRAME_TIMEOUT) begin
                abort_run("Latched frames did not settle before timeout");
            end
        end
    endtask

    // ==============================
    // Latched frame checker
    // ==============================
    always @(posedge clk) begin
        if (!rst && count_err) begin
            abort_run("Latch pulse came after a wrong number of shift clocks");
        end else if (!rst && latch_stb && !frame_allowed(latched)) begin
            abort_run($sformatf("Mismatch latched: got 0x%h, expected one of %0d frames",
                                latched, allowed.size()));
        end else if (!rst && latch_stb) begin
            last_latched = latched;
            latch_count++;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        led_panel_pkg::sreg_frame_t f;
        led_panel_pkg::sreg_frame_t lit;
        led_panel_pkg::sreg_frame_t dark;
        led_panel_pkg::wb_data_t    wdat[4];
        led_panel_pkg::wb_data_t    rdat;
        int                         seed;
        int                         keep;
        bit                         seen_lit;
        bit                         seen_dark;

        seed = 57172;
        void'($urandom(seed));
        rst          = 1'b1;
        wb_req       = '0;
        cur_red      = '0;
        cur_green    = '0;
        cur_mask     = '0;
        last_latched = '0;
        latch_count  = 0;
        seen_lit     = 1'b0;
        seen_dark    = 1'b0;
        allow_config();                               // Blank frame after reset

        repeat (8) begin
            @(negedge clk);
            expect_line("sreg_d", sreg_d, 1'b0);
            expect_line("sreg_clk", sreg_clk, 1'b0);
            expect_line("sreg_ld", sreg_ld, 1'b0);
        end
        rst = 1'b0;
        wait_latch(f);
        check_frame("latched", f, expected_frame('0, '0, '0, 1'b0));

        // Readback with zero extension
        for (int a = 0; a < 4; a++) begin
            wdat[a] = $urandom();
            set_reg(led_panel_pkg::wb_addr_t'(a), wdat[a]);
        end
        for (int a = 0; a < 4; a++) begin
            bus_cycle(1'b0, led_panel_pkg::wb_addr_t'(a), '0, rdat);
            keep = (a == 3) ? led_panel_pkg::BLINK_W : led_panel_pkg::LED_COUNT;
            compare_word("wb_rsp.dat", rdat, wdat[a] & ((32'd1 << keep) - 32'd1));
        end
        set_reg(led_panel_pkg::REG_BLINK_HALF, '0);
        set_reg(led_panel_pkg::REG_BLINK_MASK, '0);
        wait_settled();
        check_frame("latched", last_latched, expected_frame(cur_red, cur_green, '0, 1'b0));

        allowed.delete();
        allow_config();
        repeat (4) begin
            set_reg(led_panel_pkg::REG_RED, $urandom());
            set_reg(led_panel_pkg::REG_GREEN, $urandom());
            wait_settled();
            check_frame("latched", last_latched, expected_frame(cur_red, cur_green, '0, 1'b0));
        end

        // Writes land while a transfer runs
        repeat (6) begin
            set_reg(led_panel_pkg::REG_RED, $urandom());
            set_reg(led_panel_pkg::REG_GREEN, $urandom());
            repeat (10 + ($urandom() % 111)) @(negedge clk);
        end
        wait_settled();
        check_frame("latched", last_latched, expected_frame(cur_red, cur_green, '0, 1'b0));

        set_reg(led_panel_pkg::REG_BLINK_MASK, $urandom() | 32'd1);
        set_reg(led_panel_pkg::REG_RED, $urandom() | cur_mask);
        set_reg(led_panel_pkg::REG_GREEN, $urandom());
        wait_settled();
        lit  = expected_frame(cur_red, cur_green, cur_mask, 1'b0);
        dark = expected_frame(cur_red, cur_green, cur_mask, 1'b1);
        check_frame("latched", last_latched, lit);
        allowed.delete();
        allow_config();
        set_reg(led_panel_pkg::REG_BLINK_HALF, 150 + ($urandom() % 50));
        for (int n = 0; n < 8 && !(seen_lit && seen_dark); n++) begin
            wait_latch(f);
            seen_lit  = seen_lit | (f == lit);
            seen_dark = seen_dark | (f == dark);
        end

        if (seen_lit && seen_dark) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("Blinking did not latch both the lit and the dark frame");
        end
    end

endmodule

`default_nettype wire

//--- led_panel.f
source/led_panel_pkg.sv
source/led_wb_regs.sv
source/led_blink.sv
source/led_sreg_ser.sv
source/led_panel_top.sv
verif/sreg_chain_model.sv
verif/led_panel_tb.sv
